// ==== flist.f ====
+incdir+source
source/pixel_pkg.sv
source/conf_shift_reg.sv
source/hit_stamper.sv
source/hit_fifo.sv
source/word_serializer.sv
source/monopix_readout_top.sv
tests/tb_monopix.sv

// ==== Makefile ====
# Verilator simulation of the pixel readout testbench

VERILATOR ?= verilator
TOP       ?= tb_monopix
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
PASS_MSG  ?= Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/tb_monopix.sv ====
`timescale 1ns/10ps
`include "pixel_consts.svh"

module tb_monopix;

    localparam int Seed       = 3204;
    localparam int DrainLimit = 800; // Cycles to empty FIFO and serializer
    localparam int TokenLimit = 50;
    localparam int NumHits    = 12;
    localparam int WordBits   = `COL_BITS + `BCID_BITS;

    logic                 ClkBx;
    logic                 reset_ff;
    logic                 ConfIn;
    logic                 ConfShift;
    logic                 ConfLoad;
    logic                 ConfDefault;
    logic [`NUM_COLS-1:0] HitCol;
    logic                 Pulse;
    logic                 Read;
    logic                 ConfOut;
    logic                 HitOr;
    logic                 DataOut;
    logic                 DataValid;
    logic                 Token;

    logic [15:0]           lfsr;
    logic                  randRead;   // Read toggles randomly while set
    int                    cycleCnt;   // Mirrors the BCID counter
    logic [`CONF_BITS-1:0] chainModel;
    pixel_pkg::conf_t      tbConf;     // Expected active configuration
    pixel_pkg::hitWord_t   expQ [$];
    logic [WordBits-1:0]   rxWord;
    int                    rxBits;
    int                    mismatches;
    int                    timeouts;
    int                    wordCount;

    monopix_readout_top UUT (
        .ClkBx       (ClkBx),
        .reset_ff    (reset_ff),
        .ConfIn      (ConfIn),
        .ConfShift   (ConfShift),
        .ConfLoad    (ConfLoad),
        .ConfDefault (ConfDefault),
        .HitCol      (HitCol),
        .Pulse       (Pulse),
        .Read        (Read),
        .ConfOut     (ConfOut),
        .HitOr       (HitOr),
        .DataOut     (DataOut),
        .DataValid   (DataValid),
        .Token       (Token)
    );

    initial begin
        ClkBx = 1'b0;
        forever #20 ClkBx = ~ClkBx;
    end

    always @(posedge ClkBx) begin
        if (reset_ff) begin
            cycleCnt <= 0;
        end else begin
            cycleCnt <= cycleCnt + 1;
        end
    end

    // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic nextBit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic int randBits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            r = (r << 1) | int'(nextBit());
        end
        return r;
    endfunction

    function automatic pixel_pkg::conf_t makeConf(input logic en, input logic [15:0] sel,
                                                  input logic [15:0] mask);
        pixel_pkg::conf_t c;
        c.Enable   = en;
        c.PulseSel = sel;
        c.ColMask  = mask;
        return c;
    endfunction

    // Injection before mask and enable
    function automatic logic [15:0] effHits(input logic [15:0] hits, input logic pulse);
        logic [15:0] inj;
        inj = pulse ? tbConf.PulseSel : 16'h0000;
        if (!tbConf.Enable) begin
            return 16'h0000;
        end
        return (hits | inj) & ~tbConf.ColMask;
    endfunction

    // Expected word for one column and counter value
    function automatic pixel_pkg::hitWord_t refWord(input int col, input int cnt);
        logic [`BCID_BITS-1:0] bin;
        pixel_pkg::hitWord_t   w;
        bin    = cnt[`BCID_BITS-1:0]; // Counter wraps at 64
        w.Col  = col[`COL_BITS-1:0];
        w.Bcid = bin ^ (bin >> 1);
        return w;
    endfunction

    task automatic compareVal(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("FAILED at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic checkWord(input logic [WordBits-1:0] got);
        pixel_pkg::hitWord_t exp;
        if (expQ.size() == 0) begin
            $display("Word %h arrived at time %0t with no hit left to expect", got, $time);
            mismatches++;
        end else begin
            exp = expQ.pop_front();
            compareVal(32'(got), 32'(exp), "hit word {Col,Bcid}");
        end
        wordCount++;
    endtask

    // Collect ten serial bits into a word
    always @(posedge ClkBx) begin
        if (!reset_ff && DataValid) begin
            rxWord = {rxWord[WordBits-2:0], DataOut};
            rxBits++;
            if (rxBits == WordBits) begin
                rxBits = 0;
                checkWord(rxWord);
            end
        end
    end

    task automatic tick(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge ClkBx);
            if (randRead) begin
                Read <= nextBit();
            end
        end
    endtask

    // One-cycle hit with expected words queued lowest column first
    task automatic applyHit(input logic [15:0] hits, input logic pulse);
        logic [15:0] eff;
        int          stampCnt;
        eff = effHits(hits, pulse);
        @(posedge ClkBx);
        HitCol   <= hits;
        Pulse    <= pulse;
        stampCnt = cycleCnt + 1; // Counter value before the sampling edge
        for (int c = 0; c < `NUM_COLS; c++) begin
            if (eff[c]) begin
                expQ.push_back(refWord(c, stampCnt));
            end
        end
        @(posedge ClkBx);
        compareVal(32'(HitOr), 32'(|eff), "HitOr");
        HitCol <= '0;
        Pulse  <= 1'b0;
    endtask

    task automatic loadDefault();
        @(posedge ClkBx);
        ConfDefault <= 1'b1;
        @(posedge ClkBx);
        ConfDefault <= 1'b0;
        tbConf     = makeConf(1'b0, 16'h0000, 16'hFFFF);
        chainModel = tbConf;
    endtask

    // Old chain leaves on ConfOut while the new one shifts in MSB first
    task automatic configure(input pixel_pkg::conf_t newConf);
        logic [`CONF_BITS-1:0] bits;
        bits = newConf;
        for (int k = 0; k < `CONF_BITS; k++) begin
            @(posedge ClkBx);
            if (k > 0) begin
                compareVal(32'(ConfOut), 32'(chainModel[`CONF_BITS - k]), "ConfOut");
            end
            ConfShift <= 1'b1;
            ConfIn    <= bits[`CONF_BITS - 1 - k];
        end
        @(posedge ClkBx);
        compareVal(32'(ConfOut), 32'(chainModel[0]), "ConfOut");
        ConfShift <= 1'b0;
        ConfLoad  <= 1'b1;
        @(posedge ClkBx);
        ConfLoad   <= 1'b0;
        chainModel = bits;
        tbConf     = newConf;
    endtask

    task automatic waitDrained();
        int n;
        n = 0;
        while ((expQ.size() != 0 || Token) && n < DrainLimit) begin
            tick(1);
            n++;
        end
        if (expQ.size() != 0 || Token) begin
            $display("Timeout: %0d words still missing after %0d cycles", expQ.size(), n);
            timeouts++;
            expQ.delete();
        end
    endtask

    task automatic waitToken();
        int n;
        n = 0;
        while (!Token && n < TokenLimit) begin
            @(posedge ClkBx);
            n++;
        end
        if (!Token) begin
            $display("Timeout: Token never rose while words were held back");
            timeouts++;
        end
    endtask

    initial begin
        logic [15:0] hits;
        reset_ff    = 1'b1;
        ConfIn      = 1'b0;
        ConfShift   = 1'b0;
        ConfLoad    = 1'b0;
        ConfDefault = 1'b0;
        HitCol      = '0;
        Pulse       = 1'b0;
        Read        = 1'b0;
        lfsr        = 16'(Seed);
        randRead    = 1'b0;
        rxWord      = '0;
        rxBits      = 0;
        mismatches  = 0;
        timeouts    = 0;
        wordCount   = 0;
        tbConf      = makeConf(1'b0, 16'h0000, 16'hFFFF);
        chainModel  = tbConf;
        repeat (3) @(posedge ClkBx);
        reset_ff <= 1'b0;
        @(posedge ClkBx);
        compareVal(32'(Token), 0, "Token after reset");
        compareVal(32'(DataValid), 0, "DataValid after reset");
        compareVal(32'(DataOut), 0, "DataOut after reset");
        compareVal(32'(HitOr), 0, "HitOr after reset");
        compareVal(32'(ConfOut), 0, "ConfOut after reset");

        // Default config and a fully masked pattern give no words
        loadDefault();
        Read <= 1'b1;
        applyHit(16'(randBits(16)), 1'b1);
        configure(makeConf(1'b1, 16'hA5C3, 16'hFFFF));
        applyHit(16'hFFFF, 1'b1);
        applyHit(16'(randBits(16)), 1'b0);
        for (int i = 0; i < 30; i++) begin
            @(posedge ClkBx);
            compareVal(32'(Token), 0, "Token with all columns masked");
        end

        // Single hits on random columns
        configure(makeConf(1'b1, 16'h0000, 16'h0000));
        randRead = 1'b1;
        for (int i = 0; i < NumHits; i++) begin
            tick(randBits(3));
            applyHit(16'(1) << randBits(4), 1'b0);
            waitDrained();
        end

        // Same-cycle hits come out in ascending columns
        for (int i = 0; i < 4; i++) begin
            hits = 16'(randBits(16));
            if ($countones(hits) < 2) begin
                hits = hits | 16'h0101;
            end
            tick(randBits(3));
            applyHit(hits, 1'b0);
            waitDrained();
        end

        // Injection only where selected and unmasked
        configure(makeConf(1'b1, 16'h3C3C, 16'h0F0F));
        applyHit(16'h0000, 1'b1);
        waitDrained();
        applyHit(16'h0081, 1'b1);
        waitDrained();
        for (int i = 0; i < 3; i++) begin
            hits = 16'(randBits(16));
            applyHit(hits, nextBit());
            waitDrained();
        end

        // Words pile up in FIFO and pending flags while Read is low
        configure(makeConf(1'b1, 16'h0000, 16'h0000));
        randRead = 1'b0;
        @(posedge ClkBx);
        Read <= 1'b0;
        for (int c = 0; c < NumHits; c++) begin
            applyHit(16'(1) << c, 1'b0);
            tick(randBits(2));
        end
        waitToken();
        for (int i = 0; i < 20; i++) begin
            @(posedge ClkBx);
            compareVal(32'(Token), 1, "Token while Read is low");
            compareVal(32'(DataValid), 0, "DataValid while Read is low");
        end
        Read <= 1'b1;
        waitDrained();

        $display("Errors: %0d mismatches, %0d timeouts, %0d words received",
                 mismatches, timeouts, wordCount);
        if (mismatches == 0 && timeouts == 0 && wordCount > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== source/monopix_readout_top.sv ====
`timescale 1ns/10ps
`include "pixel_consts.svh"

module monopix_readout_top (
    input  logic                 ClkBx,
    input  logic                 reset_ff,
    input  logic                 ConfIn,
    input  logic                 ConfShift,
    input  logic                 ConfLoad,
    input  logic                 ConfDefault,
    input  logic [`NUM_COLS-1:0] HitCol,
    input  logic                 Pulse,
    input  logic                 Read,
    output logic                 ConfOut,
    output logic                 HitOr,
    output logic                 DataOut,
    output logic                 DataValid,
    output logic                 Token
);

    pixel_pkg::conf_t    activeConf;
    pixel_pkg::hitWord_t stampWord; // Stamper to FIFO
    pixel_pkg::hitWord_t fifoWord;  // FIFO to serializer

    logic stampValid;
    logic stampReady;
    logic fifoValid;
    logic fifoReady;

    conf_shift_reg confReg (
        .ClkBx       (ClkBx),
        .reset_ff    (reset_ff),
        .ConfIn      (ConfIn),
        .ConfShift   (ConfShift),
        .ConfLoad    (ConfLoad),
        .ConfDefault (ConfDefault),
        .ConfOut     (ConfOut),
        .Conf        (activeConf)
    );

    hit_stamper stamper (
        .ClkBx    (ClkBx),
        .reset_ff (reset_ff),
        .HitCol   (HitCol),
        .Pulse    (Pulse),
        .Conf     (activeConf),
        .HitOr    (HitOr),
        .HitWord  (stampWord),
        .HitValid (stampValid),
        .HitReady (stampReady)
    );

    hit_fifo fifo (
        .ClkBx    (ClkBx),
        .reset_ff (reset_ff),
        .InWord   (stampWord),
        .InValid  (stampValid),
        .InReady  (stampReady),
        .OutWord  (fifoWord),
        .OutValid (fifoValid),
        .OutReady (fifoReady)
    );

    word_serializer serializer (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .Read      (Read),
        .InWord    (fifoWord),
        .InValid   (fifoValid),
        .InReady   (fifoReady),
        .DataOut   (DataOut),
        .DataValid (DataValid),
        .Token     (Token)
    );

endmodule

// ==== source/word_serializer.sv ====
`timescale 1ns/10ps

module word_serializer (
    input  logic                ClkBx,
    input  logic                reset_ff,
    input  logic                Read,
    input  pixel_pkg::hitWord_t InWord,
    input  logic                InValid,
    output logic                InReady,
    output logic                DataOut,
    output logic                DataValid,
    output logic                Token
);

    localparam int WordBits = $bits(pixel_pkg::hitWord_t);
    localparam int CntBits  = $clog2(WordBits);
    localparam logic [CntBits-1:0] LastBit = CntBits'(WordBits - 1);

    pixel_pkg::serState_t state;

    logic [WordBits-1:0] shReg;  // MSB is the bit on the line
    logic [CntBits-1:0]  bitCnt; // Bits already driven of this word
    logic                lastBit;
    logic                take;

    assign lastBit = (state == pixel_pkg::SerShift) && (bitCnt == LastBit);

    // Next word is fetched on the last bit, so words run back to back
    assign InReady = Read && ((state == pixel_pkg::SerIdle) || lastBit);
    assign take    = InValid && InReady;

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            state  <= pixel_pkg::SerIdle;
            bitCnt <= '0;
        end else begin
            case (state)
                pixel_pkg::SerIdle: begin
                    if (take) begin
                        state  <= pixel_pkg::SerShift;
                        bitCnt <= '0;
                    end
                end
                pixel_pkg::SerShift: begin
                    if (lastBit) begin
                        bitCnt <= '0;
                        if (!take) begin
                            state <= pixel_pkg::SerIdle;
                        end
                    end else begin
                        bitCnt <= bitCnt + 1'b1;
                    end
                end
                default: state <= pixel_pkg::SerIdle;
            endcase
        end
    end

    always_ff @(posedge ClkBx) begin
        if (take) begin
            shReg <= InWord;
        end else if (state == pixel_pkg::SerShift) begin
            shReg <= {shReg[WordBits-2:0], 1'b0};
        end
    end

    assign DataValid = (state == pixel_pkg::SerShift);
    assign DataOut   = DataValid && shReg[WordBits-1];

    // Data waiting in the FIFO or still on the line
    assign Token = InValid || DataValid;

endmodule

// ==== source/hit_fifo.sv ====
`timescale 1ns/10ps
`include "pixel_consts.svh"

module hit_fifo (
    input  logic                ClkBx,
    input  logic                reset_ff,
    input  pixel_pkg::hitWord_t InWord,
    input  logic                InValid,
    output logic                InReady,
    output pixel_pkg::hitWord_t OutWord,
    output logic                OutValid,
    input  logic                OutReady
);

    localparam int PtrBits = $clog2(`FIFO_DEPTH);
    localparam int CntBits = $clog2(`FIFO_DEPTH + 1);
    localparam logic [PtrBits-1:0] LastPtr = PtrBits'(`FIFO_DEPTH - 1);
    localparam logic [CntBits-1:0] FullCnt = CntBits'(`FIFO_DEPTH);

    pixel_pkg::hitWord_t mem [`FIFO_DEPTH];

    logic [PtrBits-1:0] wrPtr;
    logic [PtrBits-1:0] rdPtr;
    logic [CntBits-1:0] count;
    logic               full;
    logic               wrEn;
    logic               rdEn;

    assign full     = (count == FullCnt);
    assign OutValid = (count != '0);
    assign OutWord  = mem[rdPtr]; // Fall-through, head is always on the output

    // Full FIFO still takes a word when one leaves in the same cycle
    assign InReady = !full || OutReady;
    assign wrEn    = InValid && InReady;
    assign rdEn    = OutValid && OutReady;

    always_ff @(posedge ClkBx) begin
        if (wrEn) begin
            mem[wrPtr] <= InWord;
        end
    end

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (wrEn) begin
                wrPtr <= (wrPtr == LastPtr) ? '0 : wrPtr + 1'b1;
            end
            if (rdEn) begin
                rdPtr <= (rdPtr == LastPtr) ? '0 : rdPtr + 1'b1;
            end
            case ({wrEn, rdEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither
            endcase
        end
    end

endmodule

// ==== source/hit_stamper.sv ====
`timescale 1ns/10ps
`include "pixel_consts.svh"

module hit_stamper (
    input  logic                 ClkBx,
    input  logic                 reset_ff,
    input  logic [`NUM_COLS-1:0] HitCol,
    input  logic                 Pulse,
    input  pixel_pkg::conf_t     Conf,
    output logic                 HitOr,
    output pixel_pkg::hitWord_t  HitWord,
    output logic                 HitValid,
    input  logic                 HitReady
);

    logic [`BCID_BITS-1:0] bcidBin;
    logic [`BCID_BITS-1:0] bcidGray;
    logic [`NUM_COLS-1:0]  effHit;
    logic [`NUM_COLS-1:0]  newHit;
    logic [`NUM_COLS-1:0]  pending;
    logic [`NUM_COLS-1:0]  doneMask;
    logic [`BCID_BITS-1:0] stamp [`NUM_COLS];
    logic [`COL_BITS-1:0]  lowCol;
    logic [`COL_BITS-1:0]  selCol;
    logic [`COL_BITS-1:0]  holdCol;
    logic                  holdActive;
    logic                  xfer;

    // Bunch crossing counter, binary inside
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            bcidBin <= '0;
        end else begin
            bcidBin <= bcidBin + 1'b1;
        end
    end

    assign bcidGray = bcidBin ^ (bcidBin >> 1);

    // Injection first, then mask and global enable
    assign effHit = (HitCol | ({`NUM_COLS{Pulse}} & Conf.PulseSel))
                  & ~Conf.ColMask & {`NUM_COLS{Conf.Enable}};

    assign HitOr  = |effHit;
    assign newHit = effHit & ~pending; // Busy columns drop the hit

    // Lowest pending column wins
    always_comb begin
        lowCol = '0;
        for (int i = `NUM_COLS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                lowCol = `COL_BITS'(i);
            end
        end
    end

    // A stalled offer keeps its column even if a lower one arrives
    assign selCol   = holdActive ? holdCol : lowCol;
    assign HitValid = |pending;
    assign xfer     = HitValid && HitReady;
    assign doneMask = xfer ? (`NUM_COLS'(1) << selCol) : '0;

    always_comb begin
        HitWord.Col  = selCol;
        HitWord.Bcid = stamp[selCol];
    end

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            pending    <= '0;
            holdActive <= 1'b0;
        end else begin
            pending    <= (pending & ~doneMask) | newHit;
            holdActive <= HitValid && !HitReady;
        end
    end

    always_ff @(posedge ClkBx) begin
        holdCol <= selCol;
    end

    // Timestamp is the counter value before the sampling edge
    always_ff @(posedge ClkBx) begin
        for (int i = 0; i < `NUM_COLS; i++) begin
            if (newHit[i]) begin
                stamp[i] <= bcidGray;
            end
        end
    end

endmodule

// ==== source/conf_shift_reg.sv ====
`timescale 1ns/10ps
`include "pixel_consts.svh"

module conf_shift_reg (
    input  logic              ClkBx,
    input  logic              reset_ff,
    input  logic              ConfIn,
    input  logic              ConfShift,
    input  logic              ConfLoad,
    input  logic              ConfDefault,
    output logic              ConfOut,
    output pixel_pkg::conf_t  Conf
);

    logic [`CONF_BITS-1:0] chain; // Serial chain, bit 0 is the input end
    logic                  useDefault;

    assign useDefault = reset_ff || ConfDefault;

    // Serial chain
    // New bit enters at the bottom, oldest bit leaves at the top
    always_ff @(posedge ClkBx) begin
        if (useDefault) begin
            chain <= pixel_pkg::DefaultConf;
        end else if (ConfShift) begin
            chain <= {chain[`CONF_BITS-2:0], ConfIn};
        end
    end

    // Shadow copy that drives the readout
    // Only changes on a load, so shifting never disturbs running config
    always_ff @(posedge ClkBx) begin
        if (useDefault) begin
            Conf <= pixel_pkg::DefaultConf;
        end else if (ConfLoad) begin
            Conf <= pixel_pkg::conf_t'(chain); // Takes chain before this edge's shift
        end
    end

    // Enable bit of the default is 0, so the output idles low
    assign ConfOut = chain[`CONF_BITS-1];

endmodule

// ==== source/pixel_pkg.sv ====
`include "pixel_consts.svh"

package pixel_pkg;

    // Active configuration, Enable sits at the top of the chain
    typedef struct packed {
        logic                 Enable;   // Readout enable
        logic [`NUM_COLS-1:0] PulseSel; // 1 lets Pulse inject
        logic [`NUM_COLS-1:0] ColMask;  // 1 masks the column
    } conf_t;

    // Power-up values: everything masked, no injection, readout off
    localparam conf_t DefaultConf = '{
        Enable:   1'b0,
        PulseSel: '0,
        ColMask:  '1
    };

    // One hit as it travels to the serial output
    typedef struct packed {
        logic [`COL_BITS-1:0]  Col;  // Column address
        logic [`BCID_BITS-1:0] Bcid; // Gray-coded timestamp
    } hitWord_t;

    // Serializer FSM
    typedef enum logic {
        SerIdle  = 1'b0, // Waiting for Read and a word
        SerShift = 1'b1  // Driving bits MSB first
    } serState_t;

endpackage

// ==== source/pixel_consts.svh ====
`ifndef PIXEL_CONSTS_SVH
`define PIXEL_CONSTS_SVH

// Column readout geometry

// Columns in the single readout flavor
`define NUM_COLS 16

// Column address width in a hit word
`define COL_BITS 4

// Bunch crossing timestamp width
`define BCID_BITS 6

// Hit path buffering

`define FIFO_DEPTH 8 // Words between stamper and serializer

// Configuration chain

// Enable, PulseSel and ColMask back to back
`define CONF_BITS 33

`endif
